//--- source/simd_exe_consts.svh
// ######################################################################
// SIMD execute stage constants
// Widths of one lane and of a full vector, and the lane count
// ######################################################################

`ifndef SIMD_EXE_CONSTS_SVH
`define SIMD_EXE_CONSTS_SVH

// One functional unit handles this many bits
`define SIMD_LANE_W 64

// Full vector operand as seen on the issue port
`define SIMD_VEC_W 128

// Lane 0 owns the low half of the vector
`define SIMD_LANES 2

`endif

//--- source/simd_pkg.sv
// ######################################################################
// SIMD execute stage package
// Data typedefs and the operation and element width encodings
// ######################################################################

`default_nettype none

`include "simd_exe_consts.svh"

package simd_pkg;

    typedef logic [`SIMD_LANE_W-1:0] lane_data_t;  // Data of one lane
    typedef logic [`SIMD_VEC_W-1:0]  vec_data_t;   // Lane 0 in the low half
    typedef logic [0:0]              lane_id_t;    // Lane index

    // Packed element width
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_t;

    typedef enum logic [3:0] {
        VOP_ADD   = 4'd0,
        VOP_SUB   = 4'd1,   // vs2 minus vs1
        VOP_SADDU = 4'd2,   // Unsigned saturating add
        VOP_AND   = 4'd3,
        VOP_OR    = 4'd4,
        VOP_XOR   = 4'd5,
        VOP_MINU  = 4'd6,
        VOP_MUL   = 4'd7,   // Low half of each product
        VOP_MACC  = 4'd8    // vs1 * vs2 + old vd
    } vop_t;

endpackage

`default_nettype wire

//--- source/lane_alu.sv
// ######################################################################
// Lane ALU
// Packed add, subtract, saturating add, logic ops and unsigned minimum
// on 8, 16, 32 or 64-bit elements of one 64-bit lane
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

`include "simd_exe_consts.svh"

module lane_alu (
    input  simd_pkg::vop_t       op_i,
    input  simd_pkg::sew_t       sew_i,
    input  simd_pkg::lane_data_t data_a_i,
    input  simd_pkg::lane_data_t data_b_i,
    output simd_pkg::lane_data_t data_o,
    output logic                 sat_o
);
    import simd_pkg::*;

    localparam int NBYTES = `SIMD_LANE_W / 8;

    logic [2:0]        emask;       // Byte offset bits inside one element
    logic              sub_mode;    // Two's complement of b, carry in of one
    lane_data_t        b_eff;
    lane_data_t        sum;
    logic [NBYTES-1:0] byte_cout;
    logic [NBYTES-1:0] elem_top;    // Byte is the top byte of its element
    logic [NBYTES-1:0] elem_cout;   // Carry out of the element of each byte

    always_comb begin
        case (sew_i)
            SEW_8:   emask = 3'd0;
            SEW_16:  emask = 3'd1;
            SEW_32:  emask = 3'd3;
            default: emask = 3'd7;
        endcase
    end

    assign sub_mode = (op_i == VOP_SUB) || (op_i == VOP_MINU);
    assign b_eff    = sub_mode ? ~data_b_i : data_b_i;

    // Byte-wide carry chain, broken at every element boundary
    always_comb begin
        logic carry;
        carry = 1'b0;
        for (int i = 0; i < NBYTES; i++) begin
            if ((3'(i) & emask) == 3'd0) begin
                carry = sub_mode;   // Fresh element
            end
            {carry, sum[i*8 +: 8]} = {1'b0, data_a_i[i*8 +: 8]}
                                   + {1'b0, b_eff[i*8 +: 8]} + 9'(carry);
            byte_cout[i] = carry;
            elem_top[i]  = ((3'(i + 1) & emask) == 3'd0);
        end
    end

    // Spread each element's carry out down to all of its bytes
    always_comb begin
        logic c;
        c = 1'b0;
        for (int i = NBYTES - 1; i >= 0; i--) begin
            if (elem_top[i]) begin
                c = byte_cout[i];
            end
            elem_cout[i] = c;
        end
    end

    always_comb begin
        data_o = sum;   // ADD, SUB and the MACC accumulate
        sat_o  = 1'b0;
        case (op_i)
            VOP_AND: data_o = data_a_i & data_b_i;
            VOP_OR:  data_o = data_a_i | data_b_i;
            VOP_XOR: data_o = data_a_i ^ data_b_i;
            VOP_SADDU: begin
                for (int i = 0; i < NBYTES; i++) begin
                    if (elem_cout[i]) begin
                        data_o[i*8 +: 8] = 8'hff;   // Clamp to all ones
                    end
                end
                sat_o = |(byte_cout & elem_top);
            end
            VOP_MINU: begin
                // No borrow out means a >= b
                for (int i = 0; i < NBYTES; i++) begin
                    data_o[i*8 +: 8] = elem_cout[i] ? data_b_i[i*8 +: 8]
                                                    : data_a_i[i*8 +: 8];
                end
            end
            default: data_o = sum;
        endcase
    end

endmodule

`default_nettype wire

//--- source/lane_mul.sv
// ######################################################################
// Lane multiplier
// Unsigned packed multiply, low half of each element, one register stage
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

`include "simd_exe_consts.svh"

module lane_mul (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  simd_pkg::sew_t       sew_i,
    input  simd_pkg::lane_data_t data_a_i,
    input  simd_pkg::lane_data_t data_b_i,
    output simd_pkg::lane_data_t product_o
);
    import simd_pkg::*;

    lane_data_t prod_c;

    // Slice width equals the element width, so only the low half survives
    always_comb begin
        prod_c = '0;
        case (sew_i)
            SEW_8: begin
                for (int i = 0; i < `SIMD_LANE_W / 8; i++) begin
                    prod_c[i*8 +: 8] = data_a_i[i*8 +: 8] * data_b_i[i*8 +: 8];
                end
            end
            SEW_16: begin
                for (int i = 0; i < `SIMD_LANE_W / 16; i++) begin
                    prod_c[i*16 +: 16] = data_a_i[i*16 +: 16] * data_b_i[i*16 +: 16];
                end
            end
            SEW_32: begin
                for (int i = 0; i < `SIMD_LANE_W / 32; i++) begin
                    prod_c[i*32 +: 32] = data_a_i[i*32 +: 32] * data_b_i[i*32 +: 32];
                end
            end
            default: prod_c = data_a_i * data_b_i;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            product_o <= '0;
        end else begin
            product_o <= prod_c;
        end
    end

endmodule

`default_nettype wire

//--- source/functional_unit.sv
// ######################################################################
// Functional unit, one 64-bit lane
// Latches an instruction, runs it through the ALU or the multiplier
// and holds the result until the writeback grant
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

module functional_unit (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 start_i,
    input  simd_pkg::vop_t       op_i,
    input  simd_pkg::sew_t       sew_i,
    input  simd_pkg::lane_data_t data_vs1_i,
    input  simd_pkg::lane_data_t data_vs2_i,
    input  simd_pkg::lane_data_t data_old_vd_i,
    input  logic                 grant_i,
    output logic                 valid_o,
    output simd_pkg::lane_data_t data_vd_o,
    output logic                 sat_o
);
    import simd_pkg::*;

    vop_t       op_q;
    sew_t       sew_q;
    lane_data_t vs1_q;
    lane_data_t vs2_q;
    lane_data_t old_vd_q;
    logic [1:0] lat;        // Latency of the incoming operation
    logic [1:0] cnt_q;      // Cycles left until the result is captured
    lane_data_t product;
    lane_data_t product_q;  // Extra stage before the MACC adder
    vop_t       alu_op;
    lane_data_t alu_a;
    lane_data_t alu_b;
    lane_data_t alu_res;
    logic       alu_sat;

    always_comb begin
        case (op_i)
            VOP_MUL:  lat = 2'd2;
            VOP_MACC: lat = 2'd3;
            default:  lat = 2'd1;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            op_q    <= VOP_ADD;
            sew_q   <= SEW_8;
            cnt_q   <= 2'd0;
            valid_o <= 1'b0;
        end else begin
            if (start_i) begin
                op_q  <= op_i;
                sew_q <= sew_i;
                cnt_q <= lat;
            end else if (cnt_q != 2'd0) begin
                cnt_q <= cnt_q - 2'd1;
            end
            if (cnt_q == 2'd1) begin
                valid_o <= 1'b1;
            end else if (grant_i) begin
                valid_o <= 1'b0;    // Written back
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            vs1_q    <= data_vs1_i;
            vs2_q    <= data_vs2_i;
            old_vd_q <= data_old_vd_i;
        end
    end

    always_ff @(posedge clk_i) begin
        product_q <= product;
    end

    // MACC reuses the ALU adder on the registered product
    always_comb begin
        if (op_q == VOP_MACC) begin
            alu_op = VOP_ADD;
            alu_a  = product_q;
            alu_b  = old_vd_q;
        end else begin
            alu_op = op_q;
            alu_a  = vs2_q;     // SUB computes vs2 - vs1
            alu_b  = vs1_q;
        end
    end

    lane_alu u_alu (
        .op_i     (alu_op),
        .sew_i    (sew_q),
        .data_a_i (alu_a),
        .data_b_i (alu_b),
        .data_o   (alu_res),
        .sat_o    (alu_sat)
    );

    lane_mul u_mul (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .sew_i     (sew_q),
        .data_a_i  (vs1_q),
        .data_b_i  (vs2_q),
        .product_o (product)
    );

    always_ff @(posedge clk_i) begin
        if (cnt_q == 2'd1) begin
            data_vd_o <= (op_q == VOP_MUL) ? product : alu_res;
            sat_o     <= alu_sat;   // Only SADDU can set it
        end
    end

endmodule

`default_nettype wire

//--- source/issue_wb_ctrl.sv
// ######################################################################
// Issue and writeback controller
// Four-phase req/ack issue handshake, lane start pulse and round-robin
// arbitration of the shared writeback bus
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

`include "simd_exe_consts.svh"

module issue_wb_ctrl (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 issue_req_i,
    output logic                 issue_ack_o,
    output logic                 start_o,
    input  logic                 lane0_valid_i,
    input  logic                 lane1_valid_i,
    input  simd_pkg::lane_data_t lane0_data_i,
    input  simd_pkg::lane_data_t lane1_data_i,
    input  logic                 lane0_sat_i,
    input  logic                 lane1_sat_i,
    output logic                 lane0_grant_o,
    output logic                 lane1_grant_o,
    output logic                 wb_valid_o,
    output simd_pkg::lane_id_t   wb_lane_o,
    output simd_pkg::lane_data_t wb_data_o,
    output logic                 wb_sat_o
);
    import simd_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        RUN,        // Lanes busy, writebacks counted
        ACK,
        RELEASE     // Ack high, waiting for req to drop
    } ctrl_state_t;

    ctrl_state_t state_q;
    lane_id_t    ptr_q;     // Lane with priority
    logic [1:0]  wb_cnt_q;
    logic        any_grant;

    assign lane0_grant_o = (state_q == RUN) && lane0_valid_i
                           && ((ptr_q == 1'b0) || !lane1_valid_i);
    assign lane1_grant_o = (state_q == RUN) && lane1_valid_i
                           && ((ptr_q == 1'b1) || !lane0_valid_i);
    assign any_grant     = lane0_grant_o || lane1_grant_o;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q     <= IDLE;
            ptr_q       <= '0;
            wb_cnt_q    <= 2'd0;
            start_o     <= 1'b0;
            issue_ack_o <= 1'b0;
            wb_valid_o  <= 1'b0;
        end else begin
            start_o    <= 1'b0;
            wb_valid_o <= any_grant;
            if (any_grant) begin
                ptr_q <= lane_id_t'(lane0_grant_o);  // Other lane next
            end
            case (state_q)
                IDLE: begin
                    if (issue_req_i) begin
                        start_o  <= 1'b1;
                        wb_cnt_q <= 2'd0;
                        state_q  <= RUN;
                    end
                end
                RUN: begin
                    if (any_grant) begin
                        wb_cnt_q <= wb_cnt_q + 2'd1;
                        if (wb_cnt_q == 2'(`SIMD_LANES - 1)) begin
                            state_q <= ACK;     // Last lane granted
                        end
                    end
                end
                ACK: begin
                    issue_ack_o <= 1'b1;
                    state_q     <= RELEASE;
                end
                RELEASE: begin
                    if (!issue_req_i) begin
                        issue_ack_o <= 1'b0;
                        state_q     <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (any_grant) begin
            wb_lane_o <= lane_id_t'(lane1_grant_o);
            wb_data_o <= lane1_grant_o ? lane1_data_i : lane0_data_i;
            wb_sat_o  <= lane1_grant_o ? lane1_sat_i : lane0_sat_i;
        end
    end

endmodule

`default_nettype wire

//--- source/simd_exe_top.sv
// ######################################################################
// SIMD execute stage top level
// Two 64-bit lanes behind one issue port and one writeback bus
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

`include "simd_exe_consts.svh"

module simd_exe_top (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  logic                 issue_req_i,
    output logic                 issue_ack_o,
    input  simd_pkg::vop_t       op_i,
    input  simd_pkg::sew_t       sew_i,
    input  simd_pkg::vec_data_t  vs1_i,
    input  simd_pkg::vec_data_t  vs2_i,
    input  simd_pkg::vec_data_t  old_vd_i,
    output logic                 wb_valid_o,
    output simd_pkg::lane_id_t   wb_lane_o,
    output simd_pkg::lane_data_t wb_data_o,
    output logic                 wb_sat_o
);
    import simd_pkg::*;

    logic                   start;
    logic [`SIMD_LANES-1:0] lane_valid;
    logic [`SIMD_LANES-1:0] lane_sat;
    logic [`SIMD_LANES-1:0] lane_grant;
    lane_data_t             lane_data [`SIMD_LANES];

    for (genvar g = 0; g < `SIMD_LANES; g++) begin : g_lane
        functional_unit u_fu (
            .clk_i         (clk_i),
            .rstn_i        (rstn_i),
            .start_i       (start),
            .op_i          (op_i),
            .sew_i         (sew_i),
            .data_vs1_i    (vs1_i[g*`SIMD_LANE_W +: `SIMD_LANE_W]),    // Own half
            .data_vs2_i    (vs2_i[g*`SIMD_LANE_W +: `SIMD_LANE_W]),
            .data_old_vd_i (old_vd_i[g*`SIMD_LANE_W +: `SIMD_LANE_W]),
            .grant_i       (lane_grant[g]),
            .valid_o       (lane_valid[g]),
            .data_vd_o     (lane_data[g]),
            .sat_o         (lane_sat[g])
        );
    end

    issue_wb_ctrl u_ctrl (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .issue_req_i   (issue_req_i),
        .issue_ack_o   (issue_ack_o),
        .start_o       (start),
        .lane0_valid_i (lane_valid[0]),
        .lane1_valid_i (lane_valid[1]),
        .lane0_data_i  (lane_data[0]),
        .lane1_data_i  (lane_data[1]),
        .lane0_sat_i   (lane_sat[0]),
        .lane1_sat_i   (lane_sat[1]),
        .lane0_grant_o (lane_grant[0]),
        .lane1_grant_o (lane_grant[1]),
        .wb_valid_o    (wb_valid_o),
        .wb_lane_o     (wb_lane_o),
        .wb_data_o     (wb_data_o),
        .wb_sat_o      (wb_sat_o)
    );

endmodule

`default_nettype wire

//--- tests/simd_exe_checker.sv
// ######################################################################
// SIMD execute stage protocol checker
// Concurrent assertions on the issue handshake and the writeback bus
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

module simd_exe_checker (
    input logic clk_i,
    input logic rstn_i,
    input logic req_i,
    input logic ack_i,
    input logic wb_valid_i
);

    // Ack only answers a pending request
    ack_needs_req: assert property (@(posedge clk_i) disable iff (!rstn_i)
        $rose(ack_i) |-> req_i)
        else $error("issue ack rose while req was low");

    // Both writebacks are done before ack
    no_wb_during_ack: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(wb_valid_i && ack_i))
        else $error("writeback valid while issue ack is high");

    ack_held: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (ack_i && req_i) |=> ack_i)
        else $error("issue ack fell before req was released");

endmodule

bind simd_exe_top simd_exe_checker i_checker (
    .clk_i      (clk_i),
    .rstn_i     (rstn_i),
    .req_i      (issue_req_i),
    .ack_i      (issue_ack_o),
    .wb_valid_i (wb_valid_o)
);

`default_nettype wire

//--- tests/simd_exe_tb.sv
// ######################################################################
// SIMD execute stage testbench
// Reads transactions from the stimulus file, drives the issue port and
// checks both lane writebacks of every instruction
// ######################################################################

`timescale 1ns/1ps
`default_nettype none

`include "simd_exe_consts.svh"

module simd_exe_tb;
    import simd_pkg::*;

    localparam int CLK_HALF   = 20;
    localparam int RST_CYCLES = 4;
    localparam int SEED       = 81518;

    logic       clk_i = 1'b0;
    logic       rstn_i;
    logic       issue_req;
    logic       issue_ack;
    vop_t       op;
    sew_t       sew;
    vec_data_t  vs1;
    vec_data_t  vs2;
    vec_data_t  old_vd;
    logic       wb_valid;
    lane_id_t   wb_lane;
    lane_data_t wb_data;
    logic       wb_sat;

    // One entry per stimulus line
    string      t_name [$];
    logic [3:0] t_op [$];
    logic [1:0] t_sew [$];
    vec_data_t  t_vs1 [$];
    vec_data_t  t_vs2 [$];
    vec_data_t  t_old [$];
    vec_data_t  t_exp [$];
    logic [1:0] t_sat [$];    // Bit 1 for lane 1
    int         n_tests = 0;

    simd_exe_top i_dut (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .issue_req_i (issue_req),
        .issue_ack_o (issue_ack),
        .op_i        (op),
        .sew_i       (sew),
        .vs1_i       (vs1),
        .vs2_i       (vs2),
        .old_vd_i    (old_vd),
        .wb_valid_o  (wb_valid),
        .wb_lane_o   (wb_lane),
        .wb_data_o   (wb_data),
        .wb_sat_o    (wb_sat)
    );

    always #(CLK_HALF) clk_i = ~clk_i;

    task automatic abort_run(input string msg);
        $display("ERROR: %0s", msg);
        $display("TEST FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic check_data(input string name, input lane_data_t exp, input lane_data_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %0s wb_data_o: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_lane(input string name, input lane_id_t exp, input lane_id_t act);
        if (act !== exp) begin
            $display("CHECK FAILED %0s wb_lane_o: expected %h, actual %h", name, exp, act);
            $display("TEST FAILED");
            $fatal(1, "lane mismatch");
        end
    endtask

    task automatic check_bit(input string name, input string what, input logic exp,
                             input logic act);
        if (act !== exp) begin
            $display("CHECK FAILED %0s %0s: expected %b, actual %b", name, what, exp, act);
            $display("TEST FAILED");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic load_stimulus();
        int           fd;
        int           n;
        string        line;
        logic [255:0] name_raw;
        logic [3:0]   op_v;
        logic [1:0]   sew_v;
        vec_data_t    a;
        vec_data_t    b;
        vec_data_t    c;
        vec_data_t    e;
        logic         s0;
        logic         s1;
        fd = $fopen("tests/simd_exe_stimulus.txt", "r");
        if (fd == 0) abort_run("cannot open tests/simd_exe_stimulus.txt");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != 8'h23) begin    // Skip # lines
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h",
                            name_raw, op_v, sew_v, a, b, c, e, s0, s1);
                if (n != 9) abort_run($sformatf("malformed stimulus line: %0s", line));
                t_name.push_back($sformatf("%0s", name_raw));
                t_op.push_back(op_v);
                t_sew.push_back(sew_v);
                t_vs1.push_back(a);
                t_vs2.push_back(b);
                t_old.push_back(c);
                t_exp.push_back(e);
                t_sat.push_back({s1, s0});
            end
        end
        $fclose(fd);
    endtask

    task automatic check_idle(input string name);
        @(negedge clk_i);
        check_bit(name, "issue_ack_o", 1'b0, issue_ack);
        check_bit(name, "wb_valid_o", 1'b0, wb_valid);
    endtask

    task automatic run_transaction(input int idx);
        int         gap;
        int         wb_count;
        lane_id_t   cur;
        vec_data_t  exp_vec;
        lane_data_t exp_lane [2];
        logic [1:0] exp_sat;
        string      name;
        name        = t_name[idx];
        exp_vec     = t_exp[idx];
        exp_lane[0] = exp_vec[`SIMD_LANE_W-1:0];
        exp_lane[1] = exp_vec[`SIMD_VEC_W-1:`SIMD_LANE_W];
        exp_sat     = t_sat[idx];
        gap         = $urandom_range(3, 0);
        repeat (gap) @(posedge clk_i);
        @(posedge clk_i);
        issue_req <= 1'b1;
        op        <= vop_t'(t_op[idx]);
        sew       <= sew_t'(t_sew[idx]);
        vs1       <= t_vs1[idx];
        vs2       <= t_vs2[idx];
        old_vd    <= t_old[idx];
        wb_count  = 0;
        do begin
            @(negedge clk_i);
            if (wb_valid) begin
                if (wb_count > 1) abort_run($sformatf("%0s: third writeback", name));
                cur = lane_id_t'(wb_count);     // Lane 0 always first
                check_lane(name, cur, wb_lane);
                check_data(name, exp_lane[cur], wb_data);
                check_bit(name, "wb_sat_o", exp_sat[cur], wb_sat);
                wb_count++;
            end
        end while (!issue_ack);
        if (wb_count != 2) begin
            abort_run($sformatf("%0s: %0d writebacks before ack, two expected",
                                name, wb_count));
        end
        @(posedge clk_i);
        issue_req <= 1'b0;
        do begin
            @(negedge clk_i);
        end while (issue_ack);    // Ack drops once req is seen low
    endtask

    initial begin : watchdog
        wait (n_tests > 0);
        repeat (n_tests * 20 + 100) @(posedge clk_i);
        $display("ERROR: the run hung, watchdog expired after %0d clock periods",
                 n_tests * 20 + 100);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin : main
        issue_req <= 1'b0;
        op        <= VOP_ADD;
        sew       <= SEW_8;
        vs1       <= '0;
        vs2       <= '0;
        old_vd    <= '0;
        rstn_i    <= 1'b0;
        void'($urandom(SEED));
        load_stimulus();
        n_tests = t_name.size();
        if (n_tests == 0) abort_run("stimulus file holds no transactions");
        repeat (RST_CYCLES) check_idle("reset");
        @(posedge clk_i);
        rstn_i <= 1'b1;
        repeat (2) check_idle("idle_after_reset");   // Quiet until first request
        for (int i = 0; i < n_tests; i++) begin
            run_transaction(i);
        end
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

//--- simd_exe.f
+incdir+source
source/simd_pkg.sv
source/lane_alu.sv
source/lane_mul.sv
source/functional_unit.sv
source/issue_wb_ctrl.sv
source/simd_exe_top.sv
tests/simd_exe_checker.sv
tests/simd_exe_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the SIMD execute stage testbench with Verilator and runs it.
# The run passes only if the log holds the pass line of the testbench.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
{ verilator --binary --timing --assert -f simd_exe.f --top-module simd_exe_tb \
    -o simd_exe_sim && ./obj_dir/simd_exe_sim; } > sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

//--- tests/simd_exe_stimulus.txt
# name op sew vs1 vs2 old_vd expected sat0 sat1, all hex, lane 1 in the high 64 bits
# op: 0 add 1 sub 2 saddu 3 and 4 or 5 xor 6 minu 7 mul 8 macc; sew: 0 e8 1 e16 2 e32 3 e64
add_e8    0 0 0102030405060708ff01ff01ff01ff01 10203040506070f90101010101010101 0 11223344556677010002000200020002 0 0
add_e16   0 1 1234567800ff0f0fffff000180007fff 11111111000111110001ffff80000001 0 23456789010020200000000000008000 0 0
add_e32   0 2 7fffffff12345678ffffffff00000001 00000001111111110000000100000002 0 80000000234567890000000000000003 0 0
add_e64   0 3 00000000ffffffffffffffffffffffff 00000000000000010000000000000002 0 00000001000000000000000000000001 0 0
sub_e8    1 0 00000000000000810101010101010101 80808080808080800010203040506070 0 80808080808080ffff0f1f2f3f4f5f6f 0 0
sub_e64   1 3 00000000000000010000000000000001 00000000000000000000000100000000 0 ffffffffffffffff00000000ffffffff 0 0
saddu_e8  2 0 0102030405060708f0f0f0f0f0f0f0f0 10101010101010100f10000120300001 0 1112131415161718fffff0f1fffff0f1 1 0
saddu_e16 2 1 ffff00018000000000ff00ff00ff00ff 0001fffe800000010001000100010001 0 ffffffffffff00010100010001000100 0 1
saddu_e32 2 2 00000001000000008000000000000001 ffffffff0000000080000000fffffffe 0 ffffffff00000000ffffffffffffffff 1 1
saddu_e64 2 3 00000000000000017fffffffffffffff ffffffffffffffff8000000000000000 0 ffffffffffffffffffffffffffffffff 0 1
and_e8    3 0 123456789abcdef0f0f0f0f0f0f0f0f0 0f0f0f0f0f0f0f0fff00ff00ff00ff00 0 020406080a0c0e00f000f000f000f000 0 0
or_e16    4 1 1200340056007800f0f0f0f0f0f0f0f0 00340056007800900f000f000f000f00 0 1234345656787890fff0fff0fff0fff0 0 0
xor_e32   5 2 aaaaaaaa55555555ffffffffffffffff 55555555555555550123456789abcdef 0 ffffffff00000000fedcba9876543210 0 0
minu_e8   6 0 000000000000000001ff807f00102030 ffffffffffffffff02fe7f8000203010 0 000000000000000001fe7f7f00102010 0 0
minu_e16  6 1 000000010000000280000001ffff1234 00010000000200007fff0100fffe1234 0 00000000000000007fff0001fffe1234 0 0
minu_e64  6 3 00000001ffffffff8000000000000000 00000002000000007fffffffffffffff 0 00000001ffffffff7fffffffffffffff 0 0
mul_e8    7 0 01010101010101010203040510ff8002 07060504030201000304050610ff0281 0 0706050403020100060c141e00010002 0 0
mul_e32   7 2 00000003000000070001000000000002 000000050000000600010000ffffffff 0 0000000f0000002a00000000fffffffe 0 0
mul_e64   7 3 00000000000000100000000100000000 10000000000000010000000100000003 0 00000000000000100000000300000000 0 0
macc_e8   8 0 01010101010101010203040510ff8002 07060504030201000304050610ff0281 f0f0f0f0f0f0f0f001010101ffff0001 f7f6f5f4f3f2f1f0070d151fff000003 0 0
macc_e32  8 2 00010000000000020000000300000007 00010000ffffffff0000000500000006 1234567800000003fffffff200000001 1234567800000001000000010000002b 0 0
macc_e64  8 3 00000000000000030000000000000002 00000000000000058000000000000001 0000000000000001fffffffffffffffe 00000000000000100000000000000000 0 0
